//--- Bender.yml
package:
  name: rv_datapath

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/rv_pipe_pkg.sv
  - rtl/register_file.sv
  - rtl/instr_decode.sv
  - rtl/alu_execute.sv
  - rtl/writeback_result.sv
  - rtl/rv_datapath_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/rv_datapath_assertions.sv
      - sim/tb_rv_datapath.sv

//--- rtl/alu_execute.sv
`timescale 1ns/1ps

module alu_execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic       dec_valid,
  input  dec_op_t    dec_op,
  // Register file read ports
  output reg_addr_t  rd_addr0,
  output reg_addr_t  rd_addr1,
  input  xlen_word_t rd_data0,
  input  xlen_word_t rd_data1,
  // Result being reported this cycle, not yet in the register file
  input  logic       fwd_valid,
  input  exe_res_t   fwd_res,
  output logic       exe_valid,
  output exe_res_t   exe_res
);

  logic       fwd_ok;
  logic       fwd_hit0;
  logic       fwd_hit1;
  xlen_word_t op_a;
  xlen_word_t rs2_val;
  xlen_word_t op_b;
  xlen_word_t alu_value;

  assign rd_addr0 = dec_op.rs1;
  assign rd_addr1 = dec_op.rs2;

  // x0 and illegal results are never written, so never forwarded
  assign fwd_ok   = fwd_valid && !fwd_res.illegal && (fwd_res.rd != 5'd0);
  assign fwd_hit0 = fwd_ok && (fwd_res.rd == dec_op.rs1);
  assign fwd_hit1 = fwd_ok && (fwd_res.rd == dec_op.rs2);

  assign op_a    = fwd_hit0 ? fwd_res.value : rd_data0;
  assign rs2_val = fwd_hit1 ? fwd_res.value : rd_data1;
  assign op_b    = dec_op.use_imm ? dec_op.imm : rs2_val;

  always_comb begin
    case (dec_op.alu_op)
      ALU_ADD: alu_value = op_a + op_b;
      ALU_SUB: alu_value = op_a - op_b;
      ALU_AND: alu_value = op_a & op_b;
      ALU_OR:  alu_value = op_a | op_b;
      ALU_XOR: alu_value = op_a ^ op_b;
      // Signed compare, result is 0 or 1
      ALU_SLT: alu_value = {31'd0, $signed(op_a) < $signed(op_b)};
      // Shift amount is the low 5 bits only
      ALU_SLL: alu_value = op_a << op_b[4:0];
      ALU_SRL: alu_value = op_a >> op_b[4:0];
      default: alu_value = '0;
    endcase
  end

  assign exe_valid = dec_valid;

  always_comb begin
    exe_res.rd      = dec_op.rd;
    exe_res.illegal = dec_op.illegal;
    exe_res.value   = dec_op.illegal ? '0 : alu_value;
  end

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      instr_valid,
  input  rv_instr_u instr,
  output logic      dec_valid,
  output dec_op_t   dec_op
);

  dec_op_t dec_next;
  logic    r_base;

  // Every R-type op except SUB needs funct7 all zero
  assign r_base = (instr.r_fields.funct7 == FUNCT7_BASE);

  always_comb begin
    dec_next         = '0;
    dec_next.alu_op  = ALU_ADD;
    dec_next.rs1     = instr.r_fields.rs1;
    dec_next.rd      = instr.r_fields.rd;
    dec_next.imm     = {{20{instr.i_fields.imm[11]}}, instr.i_fields.imm};
    dec_next.illegal = 1'b0;

    case (instr.r_fields.opcode)
      OPC_OP: begin
        dec_next.rs2     = instr.r_fields.rs2;
        dec_next.use_imm = 1'b0;
        case (instr.r_fields.funct3)
          FUNCT3_ADD_SUB: begin
            if (r_base) begin
              dec_next.alu_op = ALU_ADD;
            end else if (instr.r_fields.funct7 == FUNCT7_SUB) begin
              dec_next.alu_op = ALU_SUB;
            end else begin
              dec_next.illegal = 1'b1;
            end
          end
          FUNCT3_SLL: dec_next.alu_op = ALU_SLL;
          FUNCT3_SLT: dec_next.alu_op = ALU_SLT;
          FUNCT3_XOR: dec_next.alu_op = ALU_XOR;
          FUNCT3_SRL: dec_next.alu_op = ALU_SRL;
          FUNCT3_OR:  dec_next.alu_op = ALU_OR;
          FUNCT3_AND: dec_next.alu_op = ALU_AND;
          default:    dec_next.illegal = 1'b1;
        endcase
        // SUB was handled above, the rest want funct7 clear
        if ((instr.r_fields.funct3 != FUNCT3_ADD_SUB) && !r_base) begin
          dec_next.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        // rs2 stays x0 so the immediate form never forwards on port 1
        dec_next.use_imm = 1'b1;
        case (instr.i_fields.funct3)
          FUNCT3_ADD_SUB: dec_next.alu_op = ALU_ADD;
          FUNCT3_SLT:     dec_next.alu_op = ALU_SLT;
          FUNCT3_XOR:     dec_next.alu_op = ALU_XOR;
          FUNCT3_OR:      dec_next.alu_op = ALU_OR;
          FUNCT3_AND:     dec_next.alu_op = ALU_AND;
          default:        dec_next.illegal = 1'b1;
        endcase
      end
      default: dec_next.illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec_op <= dec_next;
    end
  end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file import rv_isa_pkg::*; (
  input  logic       clk,
  // Write channel
  input  logic       wr_ena,
  input  reg_addr_t  wr_addr,
  input  xlen_word_t wr_data,
  // Two read channels
  input  reg_addr_t  rd_addr0,
  input  reg_addr_t  rd_addr1,
  output xlen_word_t rd_data0,
  output xlen_word_t rd_data1
);

  // Only x1..x31 have storage
  xlen_word_t  x_regs [1:31];
  logic [31:1] wr_enas;

  // One-hot write enable that never selects x0
  always_comb begin
    wr_enas = '0;
    if (wr_ena && (wr_addr != 5'd0)) begin
      wr_enas[wr_addr] = 1'b1;
    end
  end

  // One flop row per writable register
  for (genvar i = 1; i < 32; i++) begin : g_regs
    always_ff @(posedge clk) begin
      if (wr_enas[i]) begin
        x_regs[i] <= wr_data;
      end
    end
  end

  always_comb begin : read_mux0
    if (rd_addr0 == 5'd0) begin
      rd_data0 = '0;
    end else begin
      rd_data0 = x_regs[rd_addr0];
    end
  end

  always_comb begin : read_mux1
    if (rd_addr1 == 5'd0) begin
      rd_data1 = '0;
    end else begin
      rd_data1 = x_regs[rd_addr1];
    end
  end

endmodule

//--- rtl/rv_datapath_top.sv
`timescale 1ns/1ps

module rv_datapath_top import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      instr_valid,
  input  rv_instr_u instr,
  output logic      res_valid,
  output exe_res_t  res
);

  logic       dec_valid;
  dec_op_t    dec_op;
  reg_addr_t  rd_addr0;
  reg_addr_t  rd_addr1;
  xlen_word_t rd_data0;
  xlen_word_t rd_data1;
  logic       exe_valid;
  exe_res_t   exe_res;
  logic       wr_ena;
  reg_addr_t  wr_addr;
  xlen_word_t wr_data;

  instr_decode u_instr_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op)
  );

  // Forwarding taps the result stage outputs directly
  alu_execute u_alu_execute (
    .dec_valid (dec_valid),
    .dec_op    (dec_op),
    .rd_addr0  (rd_addr0),
    .rd_addr1  (rd_addr1),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1),
    .fwd_valid (res_valid),
    .fwd_res   (res),
    .exe_valid (exe_valid),
    .exe_res   (exe_res)
  );

  writeback_result u_writeback_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .exe_valid (exe_valid),
    .exe_res   (exe_res),
    .res_valid (res_valid),
    .res       (res),
    .wr_ena    (wr_ena),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  register_file u_register_file (
    .clk      (clk),
    .wr_ena   (wr_ena),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr0 (rd_addr0),
    .rd_addr1 (rd_addr1),
    .rd_data0 (rd_data0),
    .rd_data1 (rd_data1)
  );

endmodule

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // Architectural widths fixed by the RV32I spec
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] xlen_word_t;

  // Major opcodes handled by this datapath
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 codes shared by the register and immediate forms
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL     = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // funct7 codes, only SUB uses the alternate pattern here
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

  // R-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fields_t;

  // I-type field layout
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // One instruction word, two decodes; opcode tells which one applies
  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } rv_instr_u;

endpackage

//--- rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // ALU operations, 4 bits leaves room for SRA/SLTU later
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_e;

  // Decode to execute
  typedef struct packed {
    alu_op_e    alu_op;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       use_imm;
    xlen_word_t imm;
    logic       illegal;
  } dec_op_t;

  // Execute to result stage, also the reported result
  typedef struct packed {
    reg_addr_t  rd;
    xlen_word_t value;
    logic       illegal;
  } exe_res_t;

endpackage

//--- rtl/writeback_result.sv
`timescale 1ns/1ps

module writeback_result import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       exe_valid,
  input  exe_res_t   exe_res,
  output logic       res_valid,
  output exe_res_t   res,
  // Register file write port
  output logic       wr_ena,
  output reg_addr_t  wr_addr,
  output xlen_word_t wr_data
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= exe_valid;
    end
  end

  // Payload holds its last value between strobes
  always_ff @(posedge clk) begin
    if (exe_valid) begin
      res <= exe_res;
    end
  end

  // Write lands at the edge that ends the reporting cycle
  assign wr_ena  = res_valid && !res.illegal;
  assign wr_addr = res.rd;
  assign wr_data = res.value;

endmodule

//--- sim.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/register_file.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/writeback_result.sv
rtl/rv_datapath_top.sv
sim/clk_gen.sv
sim/rv_datapath_assertions.sv
sim/tb_rv_datapath.sv

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- sim/rv_datapath_assertions.sv
`timescale 1ns/1ps

module rv_datapath_assertions import rv_pipe_pkg::*; (
  input logic        clk,
  input logic        arst_n,
  input logic        instr_valid,
  input logic        res_valid,
  input exe_res_t    res,
  input logic [31:1] reg_wr_enas
);

  int unsigned fail_count = 0;

  // Fixed two-cycle latency with no stall anywhere
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid == $past(instr_valid, 2))
    else begin
      $error("res_valid does not follow instr_valid by two cycles");
      fail_count++;
    end

  // Watches the per-register enables inside the register file
  a_no_illegal_write: assert property (@(posedge clk) disable iff (!arst_n)
    (!res_valid || res.illegal) |-> (reg_wr_enas == '0))
    else begin
      $error("register file written without a legal result");
      fail_count++;
    end

  a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !res_valid)
    else begin
      $error("res_valid high during reset");
      fail_count++;
    end

endmodule

bind rv_datapath_top rv_datapath_assertions u_rv_datapath_assertions (
  .*,
  .reg_wr_enas (u_register_file.wr_enas)
);

//--- sim/tb_rv_datapath.sv
`timescale 1ns/1ps

module tb_rv_datapath
  import rv_isa_pkg::*, rv_pipe_pkg::*;
();

  // Instructions issued by all tests together
  localparam int N_INSTR     = 57 + 37 + 5 + 27 + 6;
  localparam int CYCLE_LIMIT = N_INSTR * 4 + 50;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  rv_instr_u   instr;
  logic        res_valid;
  exe_res_t    res;

  xlen_word_t  model_regs [32];
  exe_res_t    exp_q [$];
  int unsigned due_q [$];
  int unsigned cycle_cnt = 0;
  int          seed;

  clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk(clk));

  rv_datapath_top u_rv_datapath_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .res_valid   (res_valid),
    .res         (res)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_res(input exe_res_t exp, input exe_res_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL res rd/value/illegal expected %h/%h/%h got %h/%h/%h",
                         exp.rd, exp.value, exp.illegal, act.rd, act.value, act.illegal));
    end
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      if (exp) begin
        stop_run("No result strobe two cycles after an instruction was issued");
      end else begin
        stop_run("Result strobe seen while no instruction was due");
      end
    end
  endtask

  // RV32I rules for the supported operations
  function automatic xlen_word_t model_alu(input alu_op_e op, input xlen_word_t a, b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      // Signs differ means a is less exactly when a is negative
      ALU_SLT: return (a[31] != b[31]) ? xlen_word_t'(a[31]) : xlen_word_t'(a < b);
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(input alu_op_e op);
    case (op)
      ALU_SLL: return FUNCT3_SLL;
      ALU_SLT: return FUNCT3_SLT;
      ALU_XOR: return FUNCT3_XOR;
      ALU_SRL: return FUNCT3_SRL;
      ALU_OR:  return FUNCT3_OR;
      ALU_AND: return FUNCT3_AND;
      default: return FUNCT3_ADD_SUB;
    endcase
  endfunction

  // One instruction per falling edge with the result due two cycles on
  task automatic issue(input rv_instr_u word, input exe_res_t exp);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = word;
    exp_q.push_back(exp);
    due_q.push_back(cycle_cnt + 2);
  endtask

  task automatic drain();
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = '0;
    while (due_q.size() != 0) @(negedge clk);
  endtask

  task automatic r_type_op(input alu_op_e op, input reg_addr_t rd, rs1, rs2);
    rv_instr_u word;
    exe_res_t  exp;
    word.r_fields = {(op == ALU_SUB) ? FUNCT7_SUB : FUNCT7_BASE, rs2, rs1, funct3_of(op),
                     rd, OPC_OP};
    exp.rd      = rd;
    exp.illegal = 1'b0;
    exp.value   = model_alu(op, model_regs[rs1], model_regs[rs2]);
    if (rd != 5'd0) model_regs[rd] = exp.value;
    issue(word, exp);
  endtask

  task automatic i_type_op(input alu_op_e op, input reg_addr_t rd, rs1, input logic [11:0] imm);
    rv_instr_u word;
    exe_res_t  exp;
    word.i_fields = {imm, rs1, funct3_of(op), rd, OPC_OP_IMM};
    exp.rd      = rd;
    exp.illegal = 1'b0;
    exp.value   = model_alu(op, model_regs[rs1], {{20{imm[11]}}, imm});
    if (rd != 5'd0) model_regs[rd] = exp.value;
    issue(word, exp);
  endtask

  task automatic illegal_op(input rv_instr_u word);
    exe_res_t exp;
    exp.rd      = word.r_fields.rd;
    exp.value   = '0;
    exp.illegal = 1'b1;
    issue(word, exp);
  endtask

  // Full 32-bit constant from ADDI, SLL by x31 (11) and x30 (10), ORI
  task automatic load_word(input reg_addr_t rd, input xlen_word_t value);
    i_type_op(ALU_ADD, rd, 5'd0, {1'b0, value[31:21]});
    r_type_op(ALU_SLL, rd, rd, 5'd31);
    i_type_op(ALU_OR, rd, rd, {1'b0, value[20:10]});
    r_type_op(ALU_SLL, rd, rd, 5'd30);
    i_type_op(ALU_OR, rd, rd, {2'b00, value[9:0]});
  endtask

  task automatic immediate_ops();
    alu_op_e imm_ops [5] = '{ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT};
    for (int r = 1; r < 32; r++) i_type_op(ALU_ADD, 5'(r), 5'd0, 12'($random(seed)));
    i_type_op(ALU_ADD, 5'd1, 5'd0, 12'hfff);
    i_type_op(ALU_SLT, 5'd2, 5'd1, 12'h000);
    for (int i = 0; i < 24; i++) begin
      i_type_op(imm_ops[$unsigned($random(seed)) % 5], 5'($random(seed)), 5'($random(seed)),
                12'($random(seed)));
    end
    drain();
  endtask

  task automatic register_ops();
    i_type_op(ALU_ADD, 5'd31, 5'd0, 12'd11);
    i_type_op(ALU_ADD, 5'd30, 5'd0, 12'd10);
    load_word(5'd1, $random(seed));
    load_word(5'd2, $random(seed));
    i_type_op(ALU_ADD, 5'd3, 5'd0, 12'h800);
    i_type_op(ALU_ADD, 5'd4, 5'd0, 12'd5);
    i_type_op(ALU_ADD, 5'd29, 5'd0, 12'd31);
    for (int k = 0; k < 8; k++) begin
      r_type_op(alu_op_e'(k), 5'(10 + k), 5'd1, 5'd2);
      r_type_op(alu_op_e'(k), 5'(18 + k), 5'd3, 5'd4);
    end
    r_type_op(ALU_SUB, 5'd5, 5'd0, 5'd4);
    r_type_op(ALU_SLT, 5'd6, 5'd4, 5'd3);
    r_type_op(ALU_SLL, 5'd7, 5'd1, 5'd0);
    r_type_op(ALU_SRL, 5'd8, 5'd1, 5'd0);
    r_type_op(ALU_SLL, 5'd9, 5'd1, 5'd29);
    r_type_op(ALU_SRL, 5'd26, 5'd3, 5'd29);
    drain();
  endtask

  task automatic x0_reads();
    // Result is reported with rd 0 and x0 is then read at distances 1 to 3
    i_type_op(ALU_ADD, 5'd0, 5'd1, 12'h123);
    r_type_op(ALU_ADD, 5'd6, 5'd0, 5'd0);
    r_type_op(ALU_ADD, 5'd7, 5'd0, 5'd1);
    r_type_op(ALU_OR, 5'd8, 5'd0, 5'd0);
    drain();
    i_type_op(ALU_ADD, 5'd9, 5'd0, 12'h000);
    drain();
  endtask

  task automatic forwarding_chains();
    alu_op_e fwd_ops [4] = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR};
    reg_addr_t base;
    for (int d = 1; d <= 3; d++) begin
      base = 5'(4 * d);
      // rs1 was written d instructions back and rs2 by the one just before
      for (int i = 0; i < 9; i++) begin
        r_type_op(fwd_ops[$unsigned($random(seed)) % 4], base + 5'(i % d), base + 5'(i % d),
                  base + 5'((i + d - 1) % d));
      end
    end
    drain();
  endtask

  task automatic illegal_encodings();
    rv_instr_u word;
    word.r_fields = {7'b0000000, 5'd2, 5'd1, 3'b000, 5'd20, 7'b1111111};
    illegal_op(word);
    word.r_fields = {7'b0000001, 5'd2, 5'd1, FUNCT3_ADD_SUB, 5'd21, OPC_OP};
    illegal_op(word);
    word.r_fields = {FUNCT7_SUB, 5'd2, 5'd1, FUNCT3_SLL, 5'd22, OPC_OP};
    illegal_op(word);
    word.i_fields = {12'd3, 5'd1, FUNCT3_SLL, 5'd25, OPC_OP_IMM};
    illegal_op(word);
    // Targets must still hold their earlier values
    r_type_op(ALU_ADD, 5'd24, 5'd22, 5'd25);
    r_type_op(ALU_OR, 5'd23, 5'd20, 5'd21);
    drain();
  endtask

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  always @(negedge clk) begin : result_monitor
    logic due_now;
    due_now = (due_q.size() != 0) && (due_q[0] == cycle_cnt);
    check_valid(due_now, res_valid);
    if (due_now) begin
      check_res(exp_q.pop_front(), res);
      void'(due_q.pop_front());
    end
    if (u_rv_datapath_top.u_rv_datapath_assertions.fail_count != 0) begin
      stop_run("A concurrent assertion on the datapath failed");
    end
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_run("Timeout, the tests did not finish within the cycle limit");
    end
  end

  initial begin
    seed        = 32'h4208_1d28;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    foreach (model_regs[r]) model_regs[r] = '0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    immediate_ops();
    register_ops();
    x0_reads();
    forwarding_chains();
    illegal_encodings();
    if (u_rv_datapath_top.u_rv_datapath_assertions.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule
